/* hdl/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath widths
`define INSTRUCTION_SIZE 32
`define DATA_SIZE 64
`define IMMEDIATE_SIZE 64
`define REG_ADDR_SIZE 5
`define PC_SIZE 64

// Front end sizing
`define IQ_DEPTH 4
`define RESET_PC 64'h0000_0000_0000_0000

`endif

/* hdl/isa_pkg.sv */
`include "rv_config.svh"

package isa_pkg;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [`REG_ADDR_SIZE-1:0] rs2;
    logic [`REG_ADDR_SIZE-1:0] rs1;
    logic [2:0] funct3;
    logic [`REG_ADDR_SIZE-1:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [`REG_ADDR_SIZE-1:0] rs1;
    logic [2:0] funct3;
    logic [`REG_ADDR_SIZE-1:0] rd;
    logic [6:0] opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [`REG_ADDR_SIZE-1:0] rs2;
    logic [`REG_ADDR_SIZE-1:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic imm_12;
    logic [5:0] imm_10_5;
    logic [`REG_ADDR_SIZE-1:0] rs2;
    logic [`REG_ADDR_SIZE-1:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [`REG_ADDR_SIZE-1:0] rd;
    logic [6:0] opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm_20;
    logic [9:0] imm_10_1;
    logic imm_11;
    logic [7:0] imm_19_12;
    logic [`REG_ADDR_SIZE-1:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_t;

  // Sign-extended branch offset
  function automatic logic [`IMMEDIATE_SIZE-1:0] b_imm(instr_t w);
    return {{(`IMMEDIATE_SIZE-13){w.b.imm_12}}, w.b.imm_12, w.b.imm_11,
            w.b.imm_10_5, w.b.imm_4_1, 1'b0};
  endfunction

  // Sign-extended jump offset
  function automatic logic [`IMMEDIATE_SIZE-1:0] j_imm(instr_t w);
    return {{(`IMMEDIATE_SIZE-21){w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12,
            w.j.imm_11, w.j.imm_10_1, 1'b0};
  endfunction

endpackage

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

  // ADD first so a cleared bundle means no operation
  typedef enum logic [5:0] {
    ADD, SUB, SLL, SLT, XOR, SRL, SRA, OR, AND, LUI,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    ADDW, SUBW, SLLW, SRLW, SRAW,
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
    MULW, DIVW, DIVUW, REMW, REMUW
  } alu_op_t;

  typedef enum logic [3:0] {
    NONE,
    LB, LH, LW, LD, LBU, LHU, LWU,
    SB, SH, SW, SD
  } mem_type_t;

  typedef struct packed {
    logic regwr;
    logic alusrc;             // Immediate as second operand
    logic apc;                // PC as first operand
    logic ucjump;
    logic cjump;
    logic memtoreg;
    logic memwr;
    logic usign;
    logic ecall;
    logic unsupported;
    logic branch_prediction;
    alu_op_t aluop;
    mem_type_t memory_type;
  } control_bits;

endpackage

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module fetch_unit (
  input  logic                clk,
  input  logic                rst,
  input  logic                imem_valid,
  input  isa_pkg::instr_t     imem_word,
  input  logic                credit_return,
  output logic                imem_ready,
  output logic                iq_push,
  output logic [`PC_SIZE-1:0] iq_pc,
  output isa_pkg::instr_t     iq_word,
  output logic                iq_pred
);
  import isa_pkg::*;

  localparam int CRD_W = $clog2(`IQ_DEPTH + 1);

  logic [CRD_W-1:0]    credits;
  logic [`PC_SIZE-1:0] pc;
  logic                accept;
  logic                is_jal;
  logic                back_branch;

  assign imem_ready  = !rst && (credits != '0);
  assign accept      = imem_valid && imem_ready;
  assign is_jal      = (imem_word.j.opcode == OP_JAL);
  assign back_branch = (imem_word.b.opcode == OP_BRANCH) && imem_word.b.imm_12;

  // Credit spent at accept, since the push follows one cycle later
  always_ff @(posedge clk) begin
    if (rst)
      credits <= CRD_W'(`IQ_DEPTH);
    else
      credits <= credits - CRD_W'(accept) + CRD_W'(credit_return);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= `RESET_PC;
      iq_push <= 1'b0;
    end else begin
      iq_push <= accept;
      if (accept) begin
        if (is_jal)
          pc <= pc + j_imm(imem_word);
        else if (back_branch)
          pc <= pc + b_imm(imem_word);   // Predicted taken
        else
          pc <= pc + `PC_SIZE'(`INSTRUCTION_SIZE / 8);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iq_pc   <= pc;
      iq_word <= imem_word;
      iq_pred <= is_jal || back_branch;
    end
  end

endmodule

/* hdl/inst_queue.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module inst_queue (
  input  logic                clk,
  input  logic                rst,
  input  logic                push,
  input  logic [`PC_SIZE-1:0] push_pc,
  input  isa_pkg::instr_t     push_word,
  input  logic                push_pred,
  input  logic                pop,
  output logic                head_valid,
  output logic [`PC_SIZE-1:0] head_pc,
  output isa_pkg::instr_t     head_word,
  output logic                head_pred,
  output logic                credit_return
);
  import isa_pkg::*;

  localparam int PTR_W = (`IQ_DEPTH > 1) ? $clog2(`IQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(`IQ_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`IQ_DEPTH - 1);

  logic [`PC_SIZE-1:0] pc_mem [`IQ_DEPTH];
  instr_t              word_mem [`IQ_DEPTH];
  logic                pred_mem [`IQ_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;

  always_ff @(posedge clk) begin
    if (push) begin
      pc_mem[wr_ptr]   <= push_pc;
      word_mem[wr_ptr] <= push_word;
      pred_mem[wr_ptr] <= push_pred;
    end
  end

  // No full check, the sender never pushes without a credit
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      count         <= count + CNT_W'(push) - CNT_W'(pop);
      credit_return <= pop;   // One credit per pop
    end
  end

  assign head_valid = (count != '0);
  assign head_pc    = pc_mem[rd_ptr];
  assign head_word  = word_mem[rd_ptr];
  assign head_pred  = pred_mem[rd_ptr];

endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module decoder (
  input  isa_pkg::instr_t             instruction,
  input  logic                        branch_taken,
  output logic [`REG_ADDR_SIZE-1:0]   register_source_1,
  output logic [`REG_ADDR_SIZE-1:0]   register_source_2,
  output logic [`REG_ADDR_SIZE-1:0]   register_destination,
  output logic [`IMMEDIATE_SIZE-1:0]  imm,
  output ctrl_pkg::control_bits       ctrl_bits
);
  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam int WORD_W = `DATA_SIZE / 2;

  logic [`IMMEDIATE_SIZE-1:0] imm_i;
  logic [`IMMEDIATE_SIZE-1:0] imm_iu;
  logic [`IMMEDIATE_SIZE-1:0] imm_s;
  logic [`IMMEDIATE_SIZE-1:0] imm_u;
  logic [`IMMEDIATE_SIZE-1:0] shamt;
  logic [2:0]                 funct3;
  logic                       alt;
  logic                       mext;

  assign register_source_1    = instruction.r.rs1;
  assign register_source_2    = instruction.r.rs2;
  assign register_destination = instruction.r.rd;

  assign funct3 = instruction.r.funct3;
  assign alt    = instruction.r.funct7[5];   // Bit 30
  assign mext   = instruction.r.funct7[0];   // Bit 25, M extension

  assign imm_i  = {{(`IMMEDIATE_SIZE-12){instruction.i.imm[11]}}, instruction.i.imm};
  assign imm_iu = {{(`IMMEDIATE_SIZE-WORD_W){1'b0}},
                   {(WORD_W-12){instruction.i.imm[11]}}, instruction.i.imm};
  assign imm_s  = {{(`IMMEDIATE_SIZE-12){instruction.s.imm_11_5[6]}},
                   instruction.s.imm_11_5, instruction.s.imm_4_0};
  assign imm_u  = {{(`IMMEDIATE_SIZE-32){instruction.u.imm_31_12[19]}},
                   instruction.u.imm_31_12, 12'b0};
  assign shamt  = {{(`IMMEDIATE_SIZE-5){1'b0}}, instruction.i.imm[4:0]};

  always_comb begin
    ctrl_bits = '0;
    imm       = '0;
    case (instruction.r.opcode)
      OP_LUI: begin
        ctrl_bits.regwr  = 1'b1;
        ctrl_bits.alusrc = 1'b1;
        ctrl_bits.aluop  = LUI;
        imm              = imm_u;
      end
      OP_AUIPC: begin
        ctrl_bits.regwr  = 1'b1;
        ctrl_bits.alusrc = 1'b1;
        ctrl_bits.apc    = 1'b1;
        imm              = imm_u;
      end
      OP_JAL: begin
        ctrl_bits.regwr  = 1'b1;
        ctrl_bits.alusrc = 1'b1;
        ctrl_bits.apc    = 1'b1;
        ctrl_bits.ucjump = 1'b1;
        imm              = j_imm(instruction);
      end
      OP_JALR: begin   // Target comes from rs1, imm stays zero
        ctrl_bits.regwr  = 1'b1;
        ctrl_bits.alusrc = 1'b1;
        ctrl_bits.ucjump = 1'b1;
      end
      OP_BRANCH: begin
        ctrl_bits.cjump = 1'b1;
        imm             = b_imm(instruction);
        case (funct3)
          3'b000:  ctrl_bits.aluop = BEQ;
          3'b001:  ctrl_bits.aluop = BNE;
          3'b100:  ctrl_bits.aluop = BLT;
          3'b101:  ctrl_bits.aluop = BGE;
          3'b110:  ctrl_bits.aluop = BLTU;
          3'b111:  ctrl_bits.aluop = BGEU;
          default: ctrl_bits.unsupported = 1'b1;
        endcase
      end
      OP_LOAD: begin
        ctrl_bits.regwr    = 1'b1;
        ctrl_bits.memtoreg = 1'b1;
        ctrl_bits.alusrc   = 1'b1;
        imm                = imm_i;
        case (funct3)
          3'b000:  ctrl_bits.memory_type = LB;
          3'b001:  ctrl_bits.memory_type = LH;
          3'b010:  ctrl_bits.memory_type = LW;
          3'b011:  ctrl_bits.memory_type = LD;
          3'b100:  ctrl_bits.memory_type = LBU;
          3'b101:  ctrl_bits.memory_type = LHU;
          3'b110:  ctrl_bits.memory_type = LWU;
          default: ctrl_bits.unsupported = 1'b1;
        endcase
      end
      OP_STORE: begin
        ctrl_bits.memwr  = 1'b1;
        ctrl_bits.alusrc = 1'b1;
        imm              = imm_s;
        case (funct3)
          3'b000:  ctrl_bits.memory_type = SB;
          3'b001:  ctrl_bits.memory_type = SH;
          3'b010:  ctrl_bits.memory_type = SW;
          3'b011:  ctrl_bits.memory_type = SD;
          default: ctrl_bits.unsupported = 1'b1;
        endcase
      end
      OP_IMM: begin
        ctrl_bits.regwr  = 1'b1;
        ctrl_bits.alusrc = 1'b1;
        imm              = imm_i;
        case (funct3)
          3'b000: ctrl_bits.aluop = ADD;
          3'b001: begin
            ctrl_bits.aluop = SLL;
            imm             = shamt;
          end
          3'b010: ctrl_bits.aluop = SLT;
          3'b011: begin   // SLTIU
            ctrl_bits.aluop = SLT;
            imm             = imm_iu;
          end
          3'b100: ctrl_bits.aluop = XOR;
          3'b101: begin
            ctrl_bits.aluop = alt ? SRA : SRL;
            imm             = shamt;
          end
          3'b110: ctrl_bits.aluop = OR;
          default: ctrl_bits.aluop = AND;
        endcase
      end
      OP_IMM32: begin
        ctrl_bits.regwr  = 1'b1;
        ctrl_bits.alusrc = 1'b1;
        imm              = imm_i;
        case (funct3)
          3'b000: ctrl_bits.aluop = ADDW;
          3'b001: begin
            ctrl_bits.aluop = SLLW;
            imm             = shamt;
          end
          3'b101: begin
            ctrl_bits.aluop = alt ? SRAW : SRLW;
            imm             = shamt;
          end
          default: ctrl_bits.unsupported = 1'b1;
        endcase
      end
      OP_REG: begin
        ctrl_bits.regwr = 1'b1;
        case (funct3)
          3'b000:  ctrl_bits.aluop = mext ? MUL : (alt ? SUB : ADD);
          3'b001:  ctrl_bits.aluop = mext ? MULH : SLL;
          3'b010:  ctrl_bits.aluop = mext ? MULHSU : SLT;
          3'b011:  ctrl_bits.aluop = mext ? MULHU : SLT;
          3'b100:  ctrl_bits.aluop = mext ? DIV : XOR;
          3'b101:  ctrl_bits.aluop = mext ? DIVU : (alt ? SRA : SRL);
          3'b110:  ctrl_bits.aluop = mext ? REM : OR;
          default: ctrl_bits.aluop = mext ? REMU : AND;
        endcase
      end
      OP_REG32: begin
        ctrl_bits.regwr = 1'b1;
        case (funct3)
          3'b000:  ctrl_bits.aluop = mext ? MULW : (alt ? SUBW : ADDW);
          3'b001:  ctrl_bits.aluop = SLLW;
          3'b100:  ctrl_bits.aluop = DIVW;
          3'b101:  ctrl_bits.aluop = mext ? DIVUW : (alt ? SRAW : SRLW);
          3'b110:  ctrl_bits.aluop = REMW;
          3'b111:  ctrl_bits.aluop = REMUW;
          default: ctrl_bits.unsupported = 1'b1;
        endcase
      end
      OP_SYSTEM: begin   // Only the bare ECALL word
        ctrl_bits.ecall       = ({instruction.u.imm_31_12, instruction.u.rd} == '0);
        ctrl_bits.unsupported = !ctrl_bits.ecall;
      end
      default: ctrl_bits.unsupported = 1'b1;
    endcase
    // SLTU and SLTIU share SLT, told apart by funct3
    ctrl_bits.usign = (ctrl_bits.aluop inside {BLTU, BGEU, MULHSU, MULHU, REMU, DIVUW, REMUW})
                   || (ctrl_bits.memory_type inside {LBU, LHU, LWU})
                   || (ctrl_bits.aluop == SLT && funct3 == 3'b011);
    ctrl_bits.branch_prediction = branch_taken;
  end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module decode_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       head_valid,
  input  logic [`PC_SIZE-1:0]        head_pc,
  input  isa_pkg::instr_t            head_word,
  input  logic                       head_pred,
  input  logic                       out_ready,
  output logic                       pop,
  output logic                       out_valid,
  output logic [`PC_SIZE-1:0]        out_pc,
  output logic [`REG_ADDR_SIZE-1:0]  rs1,
  output logic [`REG_ADDR_SIZE-1:0]  rs2,
  output logic [`REG_ADDR_SIZE-1:0]  rd,
  output logic [`IMMEDIATE_SIZE-1:0] imm,
  output ctrl_pkg::control_bits      ctrl
);
  import ctrl_pkg::*;

  logic [`REG_ADDR_SIZE-1:0]  dec_rs1;
  logic [`REG_ADDR_SIZE-1:0]  dec_rs2;
  logic [`REG_ADDR_SIZE-1:0]  dec_rd;
  logic [`IMMEDIATE_SIZE-1:0] dec_imm;
  control_bits                dec_ctrl;

  // Output register empty or draining this cycle
  assign pop = head_valid && (!out_valid || out_ready);

  decoder dec_i (
    .instruction          (head_word),
    .branch_taken         (head_pred),
    .register_source_1    (dec_rs1),
    .register_source_2    (dec_rs2),
    .register_destination (dec_rd),
    .imm                  (dec_imm),
    .ctrl_bits            (dec_ctrl)
  );

  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else if (pop)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_pc <= head_pc;
      rs1    <= dec_rs1;
      rs2    <= dec_rs2;
      rd     <= dec_rd;
      imm    <= dec_imm;
      ctrl   <= dec_ctrl;
    end
  end

endmodule

/* hdl/frontend_top.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module frontend_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       imem_valid,
  input  isa_pkg::instr_t            imem_word,
  output logic                       imem_ready,
  input  logic                       out_ready,
  output logic                       out_valid,
  output logic [`PC_SIZE-1:0]        out_pc,
  output logic [`REG_ADDR_SIZE-1:0]  rs1,
  output logic [`REG_ADDR_SIZE-1:0]  rs2,
  output logic [`REG_ADDR_SIZE-1:0]  rd,
  output logic [`IMMEDIATE_SIZE-1:0] imm,
  output ctrl_pkg::control_bits      ctrl
);
  import isa_pkg::*;

  logic                iq_push;
  logic [`PC_SIZE-1:0] iq_pc;
  instr_t              iq_word;
  logic                iq_pred;
  logic                credit_return;
  logic                iq_valid;
  logic [`PC_SIZE-1:0] head_pc;
  instr_t              head_word;
  logic                head_pred;
  logic                iq_pop;

  fetch_unit fetch_i (
    .clk           (clk),
    .rst           (rst),
    .imem_valid    (imem_valid),
    .imem_word     (imem_word),
    .credit_return (credit_return),
    .imem_ready    (imem_ready),
    .iq_push       (iq_push),
    .iq_pc         (iq_pc),
    .iq_word       (iq_word),
    .iq_pred       (iq_pred)
  );

  inst_queue queue_i (
    .clk           (clk),
    .rst           (rst),
    .push          (iq_push),
    .push_pc       (iq_pc),
    .push_word     (iq_word),
    .push_pred     (iq_pred),
    .pop           (iq_pop),
    .head_valid    (iq_valid),
    .head_pc       (head_pc),
    .head_word     (head_word),
    .head_pred     (head_pred),
    .credit_return (credit_return)
  );

  decode_stage decode_i (
    .clk        (clk),
    .rst        (rst),
    .head_valid (iq_valid),
    .head_pc    (head_pc),
    .head_word  (head_word),
    .head_pred  (head_pred),
    .out_ready  (out_ready),
    .pop        (iq_pop),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .ctrl       (ctrl)
  );

endmodule

/* verif/frontend_chk.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module frontend_chk (
  input logic                       clk,
  input logic                       rst,
  input logic                       push,
  input logic                       full,
  input logic                       pop,
  input logic                       empty,
  input logic                       out_valid,
  input logic                       out_ready,
  input logic [`PC_SIZE-1:0]        out_pc,
  input logic [`REG_ADDR_SIZE-1:0]  rs1,
  input logic [`REG_ADDR_SIZE-1:0]  rs2,
  input logic [`REG_ADDR_SIZE-1:0]  rd,
  input logic [`IMMEDIATE_SIZE-1:0] imm,
  input ctrl_pkg::control_bits      ctrl
);

  // Credits keep the queue from overflowing
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push into a full instruction queue");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("pop from an empty instruction queue");

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(rs1)
      && $stable(rs2) && $stable(rd) && $stable(imm) && $stable(ctrl))
    else $error("decoded output changed while stalled");

  a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind inst_queue frontend_chk queue_chk_i (
  .clk       (clk),
  .rst       (rst),
  .push      (push),
  .full      (count == `IQ_DEPTH),
  .pop       (pop),
  .empty     (count == '0),
  .out_valid (1'b0),
  .out_ready (1'b1),
  .out_pc    ('0),
  .rs1       ('0),
  .rs2       ('0),
  .rd        ('0),
  .imm       ('0),
  .ctrl      ('0)
);

bind decode_stage frontend_chk out_chk_i (
  .clk       (clk),
  .rst       (rst),
  .push      (1'b0),
  .full      (1'b0),
  .pop       (1'b0),
  .empty     (1'b0),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_pc    (out_pc),
  .rs1       (rs1),
  .rs2       (rs2),
  .rd        (rd),
  .imm       (imm),
  .ctrl      (ctrl)
);

/* verif/frontend_tb.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module frontend_tb;
  import isa_pkg::*;
  import ctrl_pkg::*;

  localparam int NUM_WORDS    = 2000;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_CYCLES   = NUM_WORDS * 10 + RESET_CYCLES;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       imem_valid;
  instr_t                     imem_word;
  logic                       imem_ready;
  logic                       out_ready;
  logic                       out_valid;
  logic [`PC_SIZE-1:0]        out_pc;
  logic [`REG_ADDR_SIZE-1:0]  rs1;
  logic [`REG_ADDR_SIZE-1:0]  rs2;
  logic [`REG_ADDR_SIZE-1:0]  rd;
  logic [`IMMEDIATE_SIZE-1:0] imm;
  control_bits                ctrl;

  logic [`INSTRUCTION_SIZE-1:0] word_q[$];   // Accepted, not yet decoded
  logic [`PC_SIZE-1:0]          pc_q[$];
  logic [`PC_SIZE-1:0]          model_pc;
  int                           accepted;
  int                           results;
  int                           cycles = 0;

  frontend_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .imem_valid (imem_valid),
    .imem_word  (imem_word),
    .imem_ready (imem_ready),
    .out_ready  (out_ready),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .ctrl       (ctrl)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
      abort_run($sformatf("Timeout, decoded output stalled after %0d of %0d results",
                          results, NUM_WORDS));
  end

  task automatic check_pc(input string name, input logic [`PC_SIZE-1:0] exp,
                          input logic [`PC_SIZE-1:0] act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_reg(input string name, input logic [`REG_ADDR_SIZE-1:0] exp,
                           input logic [`REG_ADDR_SIZE-1:0] act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_imm(input string name, input logic [`IMMEDIATE_SIZE-1:0] exp,
                           input logic [`IMMEDIATE_SIZE-1:0] act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_ctrl(input string name, input control_bits exp,
                            input control_bits act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  function automatic logic [`IMMEDIATE_SIZE-1:0] imm_i(logic [31:0] w);
    return `IMMEDIATE_SIZE'($signed(w[31:20]));
  endfunction

  function automatic logic [`IMMEDIATE_SIZE-1:0] imm_s(logic [31:0] w);
    return `IMMEDIATE_SIZE'($signed({w[31:25], w[11:7]}));
  endfunction

  function automatic logic [`IMMEDIATE_SIZE-1:0] imm_b(logic [31:0] w);
    return `IMMEDIATE_SIZE'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
  endfunction

  function automatic logic [`IMMEDIATE_SIZE-1:0] imm_u(logic [31:0] w);
    return `IMMEDIATE_SIZE'($signed({w[31:12], 12'h000}));
  endfunction

  function automatic logic [`IMMEDIATE_SIZE-1:0] imm_j(logic [31:0] w);
    return `IMMEDIATE_SIZE'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
  endfunction

  // Static prediction, backward branches and every JAL
  function automatic logic predicted(logic [31:0] w);
    return (w[6:0] == OP_JAL) || (w[6:0] == OP_BRANCH && w[31]);
  endfunction

  function automatic logic [`PC_SIZE-1:0] next_pc(logic [`PC_SIZE-1:0] pc, logic [31:0] w);
    if (w[6:0] == OP_JAL)
      return pc + imm_j(w);
    if (w[6:0] == OP_BRANCH && w[31])
      return pc + imm_b(w);
    return pc + `PC_SIZE'(4);
  endfunction

  task automatic expected_decode(input logic [31:0] w, input logic pred,
                                 output control_bits ctrl_exp,
                                 output logic [`IMMEDIATE_SIZE-1:0] imm_exp);
    logic [6:0] op;
    logic [2:0] f3;
    logic       alt;
    logic       mx;
    logic       sltu;
    op       = w[6:0];
    f3       = w[14:12];
    alt      = w[30];
    mx       = w[25];
    sltu     = 1'b0;
    ctrl_exp = '0;
    imm_exp  = '0;
    ctrl_exp.regwr    = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM,
                                   OP_IMM32, OP_REG, OP_REG32};
    ctrl_exp.alusrc   = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_STORE,
                                   OP_IMM, OP_IMM32};
    ctrl_exp.apc      = op inside {OP_AUIPC, OP_JAL};
    ctrl_exp.ucjump   = op inside {OP_JAL, OP_JALR};
    ctrl_exp.cjump    = (op == OP_BRANCH);
    ctrl_exp.memtoreg = (op == OP_LOAD);
    ctrl_exp.memwr    = (op == OP_STORE);
    case (op)
      OP_LUI: begin
        ctrl_exp.aluop = LUI;
        imm_exp        = imm_u(w);
      end
      OP_AUIPC: imm_exp = imm_u(w);
      OP_JAL:   imm_exp = imm_j(w);
      OP_JALR:  imm_exp = '0;
      OP_BRANCH: begin
        imm_exp = imm_b(w);
        case (f3)
          3'b000:  ctrl_exp.aluop = BEQ;
          3'b001:  ctrl_exp.aluop = BNE;
          3'b100:  ctrl_exp.aluop = BLT;
          3'b101:  ctrl_exp.aluop = BGE;
          3'b110:  ctrl_exp.aluop = BLTU;
          3'b111:  ctrl_exp.aluop = BGEU;
          default: ctrl_exp.unsupported = 1'b1;
        endcase
      end
      OP_LOAD: begin
        imm_exp = imm_i(w);
        case (f3)
          3'b000:  ctrl_exp.memory_type = LB;
          3'b001:  ctrl_exp.memory_type = LH;
          3'b010:  ctrl_exp.memory_type = LW;
          3'b011:  ctrl_exp.memory_type = LD;
          3'b100:  ctrl_exp.memory_type = LBU;
          3'b101:  ctrl_exp.memory_type = LHU;
          3'b110:  ctrl_exp.memory_type = LWU;
          default: ctrl_exp.unsupported = 1'b1;
        endcase
      end
      OP_STORE: begin
        imm_exp = imm_s(w);
        case (f3)
          3'b000:  ctrl_exp.memory_type = SB;
          3'b001:  ctrl_exp.memory_type = SH;
          3'b010:  ctrl_exp.memory_type = SW;
          3'b011:  ctrl_exp.memory_type = SD;
          default: ctrl_exp.unsupported = 1'b1;
        endcase
      end
      OP_IMM: begin
        imm_exp = imm_i(w);
        case (f3)
          3'b000: ctrl_exp.aluop = ADD;
          3'b001: begin
            ctrl_exp.aluop = SLL;
            imm_exp        = `IMMEDIATE_SIZE'(w[24:20]);
          end
          3'b010: ctrl_exp.aluop = SLT;
          3'b011: begin   // SLTIU, upper word cleared
            ctrl_exp.aluop = SLT;
            sltu           = 1'b1;
            imm_exp        = {32'h0, 32'($signed(w[31:20]))};
          end
          3'b100: ctrl_exp.aluop = XOR;
          3'b101: begin
            ctrl_exp.aluop = alt ? SRA : SRL;
            imm_exp        = `IMMEDIATE_SIZE'(w[24:20]);
          end
          3'b110:  ctrl_exp.aluop = OR;
          default: ctrl_exp.aluop = AND;
        endcase
      end
      OP_IMM32: begin
        imm_exp = imm_i(w);
        case (f3)
          3'b000: ctrl_exp.aluop = ADDW;
          3'b001: begin
            ctrl_exp.aluop = SLLW;
            imm_exp        = `IMMEDIATE_SIZE'(w[24:20]);
          end
          3'b101: begin
            ctrl_exp.aluop = alt ? SRAW : SRLW;
            imm_exp        = `IMMEDIATE_SIZE'(w[24:20]);
          end
          default: ctrl_exp.unsupported = 1'b1;
        endcase
      end
      OP_REG: begin
        case (f3)
          3'b000: ctrl_exp.aluop = mx ? MUL : (alt ? SUB : ADD);
          3'b001: ctrl_exp.aluop = mx ? MULH : SLL;
          3'b010: ctrl_exp.aluop = mx ? MULHSU : SLT;
          3'b011: begin
            ctrl_exp.aluop = mx ? MULHU : SLT;
            sltu           = !mx;
          end
          3'b100:  ctrl_exp.aluop = mx ? DIV : XOR;
          3'b101:  ctrl_exp.aluop = mx ? DIVU : (alt ? SRA : SRL);
          3'b110:  ctrl_exp.aluop = mx ? REM : OR;
          default: ctrl_exp.aluop = mx ? REMU : AND;
        endcase
      end
      OP_REG32: begin
        case (f3)
          3'b000:  ctrl_exp.aluop = mx ? MULW : (alt ? SUBW : ADDW);
          3'b001:  ctrl_exp.aluop = SLLW;
          3'b100:  ctrl_exp.aluop = DIVW;
          3'b101:  ctrl_exp.aluop = mx ? DIVUW : (alt ? SRAW : SRLW);
          3'b110:  ctrl_exp.aluop = REMW;
          3'b111:  ctrl_exp.aluop = REMUW;
          default: ctrl_exp.unsupported = 1'b1;
        endcase
      end
      OP_SYSTEM: begin
        ctrl_exp.ecall       = (w[31:7] == 25'h0);
        ctrl_exp.unsupported = !ctrl_exp.ecall;
      end
      default: ctrl_exp.unsupported = 1'b1;
    endcase
    ctrl_exp.usign = sltu
                  || (ctrl_exp.aluop inside {BLTU, BGEU, MULHSU, MULHU, REMU, DIVUW, REMUW})
                  || (ctrl_exp.memory_type inside {LBU, LHU, LWU});
    ctrl_exp.branch_prediction = pred;
  endtask

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    logic [6:0]  op;
    w = $urandom;
    if ($urandom_range(9) == 0)
      return w;   // Raw word, mostly unsupported
    case ($urandom_range(11))
      0:       op = OP_LUI;
      1:       op = OP_AUIPC;
      2:       op = OP_JAL;
      3:       op = OP_JALR;
      4:       op = OP_BRANCH;
      5:       op = OP_LOAD;
      6:       op = OP_STORE;
      7:       op = OP_IMM;
      8:       op = OP_IMM32;
      9:       op = OP_REG;
      10:      op = OP_REG32;
      default: op = OP_SYSTEM;
    endcase
    w[6:0] = op;
    if (op inside {OP_IMM, OP_IMM32, OP_REG, OP_REG32}) begin
      case ($urandom_range(3))
        0:       w[31:25] = 7'b0000000;
        1:       w[31:25] = 7'b0100000;
        2:       w[31:25] = 7'b0000001;   // M extension
        default: w[31:25] = w[31:25];
      endcase
    end
    if (op == OP_SYSTEM && $urandom_range(1) == 0)
      w[31:7] = 25'h0;   // Exact ECALL
    return w;
  endfunction

  task automatic drive_inputs();
    if (accepted < NUM_WORDS && $urandom_range(99) < 70) begin
      imem_valid = 1'b1;
      imem_word  = random_word();
    end else begin
      imem_valid = 1'b0;
      imem_word  = '0;
    end
    out_ready = ($urandom_range(99) < 60);
  endtask

  // Sampled mid low phase, values hold until the next rising edge
  task automatic observe();
    logic [31:0]                w;
    logic [`PC_SIZE-1:0]        pc;
    control_bits                ctrl_exp;
    logic [`IMMEDIATE_SIZE-1:0] imm_exp;
    if (word_q.size() > `IQ_DEPTH && imem_ready)
      abort_run("imem_ready stayed high while every queue credit was held");
    if (imem_valid && imem_ready) begin
      w = imem_word;
      word_q.push_back(w);
      pc_q.push_back(model_pc);
      model_pc = next_pc(model_pc, w);
      accepted++;
    end
    if (out_valid && out_ready) begin
      if (word_q.size() == 0)
        abort_run("Decoded result appeared with no accepted word left");
      w  = word_q.pop_front();
      pc = pc_q.pop_front();
      expected_decode(w, predicted(w), ctrl_exp, imm_exp);
      check_pc("out_pc", pc, out_pc);
      check_reg("rs1", w[19:15], rs1);
      check_reg("rs2", w[24:20], rs2);
      check_reg("rd", w[11:7], rd);
      check_imm("imm", imm_exp, imm);
      check_ctrl("ctrl", ctrl_exp, ctrl);
      results++;
    end
  endtask

  initial begin
    void'($urandom(32'hde4c79a8));
    rst        = 1'b1;
    imem_valid = 1'b0;
    imem_word  = '0;
    out_ready  = 1'b0;
    model_pc   = `RESET_PC;
    accepted   = 0;
    results    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (results < NUM_WORDS) begin
      drive_inputs();
      #1;
      observe();
      @(negedge clk);
    end
    // Drain, nothing extra may come out
    imem_valid = 1'b0;
    out_ready  = 1'b1;
    repeat (2 * `IQ_DEPTH) begin
      @(negedge clk);
      #1;
      if (out_valid)
        abort_run("Extra decoded result after every accepted word was checked");
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/fetch_unit.sv
hdl/inst_queue.sv
hdl/decoder.sv
hdl/decode_stage.sv
hdl/frontend_top.sv
verif/frontend_chk.sv
verif/frontend_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = frontend_tb
FILELIST = list.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
